// ==== run_sim.sh ====
#!/bin/sh
# build and run the frame_uart testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module frame_uart_tb -f tb.f -o frame_uart_sim

status=0
./obj_dir/frame_uart_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TB FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== tb.f ====
+incdir+verilog
verilog/frame_pkg.sv
verilog/uart_pkg.sv
verilog/frame_writer.sv
verilog/pingpong_store.sv
verilog/frame_reader.sv
verilog/uart_serializer.sv
verilog/frame_uart_top.sv
verification/frame_uart_checker.sv
verification/frame_uart_tb.sv

// ==== verification/frame_uart_checker.sv ====
/*
 * concurrent checks on the serializer
 *   bytes outstanding stay within the credit count
 *   line high in idle, stop bit high
 */

`default_nettype none

`include "frame_config.svh"

module frame_uart_checker (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire logic           tx_valid,
    input  wire logic           credit_return,
    input  wire logic           uart_tx,
    input  uart_pkg::tx_state_t state
);

    timeunit 1ns;
    timeprecision 1ps;

    int         fail_count = 0;
    logic [2:0] in_flight;              // bytes taken and not yet credited back

    always_ff @(posedge clock) begin
        if (reset) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + 3'(tx_valid) - 3'(credit_return);
        end
    end

    credits_bounded: assert property (@(posedge clock) disable iff (reset)
        in_flight <= 3'(`UART_CREDITS))
        else begin fail_count++; $error("more bytes outstanding than credits"); end

    credit_has_byte: assert property (@(posedge clock) disable iff (reset)
        credit_return |-> in_flight != '0)
        else begin fail_count++; $error("credit returned with no byte outstanding"); end

    // with every byte credited back the line rests high
    idle_line_high: assert property (@(posedge clock) disable iff (reset)
        in_flight == '0 |-> uart_tx)
        else begin fail_count++; $error("uart_tx low with no byte outstanding"); end

    // stop bit sampled mid-bit nine bit times after its start bit begins
    stop_bit_high: assert property (@(posedge clock) disable iff (reset)
        $rose(state == uart_pkg::TX_START)
            |-> ##(9 * `UART_CLOCKS_PER_BIT + `UART_CLOCKS_PER_BIT / 2) uart_tx)
        else begin fail_count++; $error("uart_tx low during the stop bit"); end

endmodule

`default_nettype wire

// ==== verification/frame_uart_tb.sv ====
/*
 * testbench for frame_uart_top
 *   clock and reset, frame stimulus with random valid gaps, vsync pulses
 *   8N1 line decoder, reference frame model, byte compare
 *   vsync_out holdoff timing, watchdog, closing summary
 */

`default_nettype none

`include "frame_config.svh"

module frame_uart_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef frame_pkg::byte_t byte_queue_t[$];

    localparam int BANK_DEPTH     = frame_pkg::BANK_DEPTH;
    localparam int BIT_CYCLES     = `UART_CLOCKS_PER_BIT;
    localparam int BYTE_CYCLES    = uart_pkg::BITS_PER_FRAME * BIT_CYCLES;
    localparam int HOLDOFF_CYCLES = `HOLDOFF_BYTES * BYTE_CYCLES;
    localparam int LEN_A          = 20;
    localparam int LEN_B          = 30;
    localparam int LEN_LONG       = BANK_DEPTH + 40;  // spills past one bank
    localparam int NUM_FRAMES     = 4;
    localparam int LINE_BYTES     = LEN_A + LEN_B + BANK_DEPTH;
    localparam longint WATCHDOG_NS = 10 * (longint'(LINE_BYTES) * BYTE_CYCLES
        + NUM_FRAMES * HOLDOFF_CYCLES + 4 * (LEN_A + LEN_B + LEN_LONG) + 20000);

    logic             clock;
    logic             reset         = 1'b1;
    frame_pkg::byte_t data_in       = '0;
    logic             data_in_valid = 1'b0;
    logic             vsync_in      = 1'b0;
    logic             uart_tx;
    logic             vsync_out;

    integer      seed            = 32'h2ee03a74;
    int          error_count     = 0;
    int          cycles          = 0;
    int          line_idle_cycle = 0;   // last stop bit end
    int          rise_cycle      = 0;
    int          fall_count      = 0;
    int          rx_count        = 0;
    byte_queue_t written_q;             // bytes of the frame being written
    byte_queue_t expect_q;              // bytes still due on the line
    byte_queue_t rx_q;
    event        byte_decoded;

    frame_uart_top dut (
        .clock        (clock),
        .reset        (reset),
        .data_in      (data_in),
        .data_in_valid(data_in_valid),
        .vsync_in     (vsync_in),
        .uart_tx      (uart_tx),
        .vsync_out    (vsync_out)
    );

    bind uart_serializer frame_uart_checker line_checker (
        .clock        (clock),
        .reset        (reset),
        .tx_valid     (tx_valid),
        .credit_return(credit_return),
        .uart_tx      (uart_tx),
        .state        (state)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model and helpers

    // what goes on the line: the written bytes, cut at the bank depth
    function automatic byte_queue_t reference_frame(byte_queue_t written);
        byte_queue_t sent;
        foreach (written[i]) begin
            if (i < BANK_DEPTH) begin
                sent.push_back(written[i]);
            end
        end
        return sent;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("error: %s is %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic write_frame(input int length);
        int gap;
        for (int i = 0; i < length; i++) begin
            gap           = $random(seed) & 3;
            data_in_valid = 1'b0;
            repeat (gap) next_cycle();
            data_in       = frame_pkg::byte_t'($random(seed));
            data_in_valid = 1'b1;
            written_q.push_back(data_in);
            next_cycle();
        end
        data_in_valid = 1'b0;
    endtask

    // closes the written frame; the model takes it over at the edge
    task automatic pulse_vsync();
        byte_queue_t frame;
        check_value("vsync_out", vsync_out, 1'b0);
        frame = reference_frame(written_q);
        foreach (frame[i]) begin
            expect_q.push_back(frame[i]);
        end
        written_q.delete();
        vsync_in = 1'b1;
        repeat (4) next_cycle();
        check_value("vsync_out", vsync_out, 1'b1);   // up since the swap
        vsync_in = 1'b0;
        repeat (2) next_cycle();
    endtask

    task automatic wait_frame_done(input int bytes);
        int limit;
        int target;
        limit  = bytes * BYTE_CYCLES + HOLDOFF_CYCLES + 4 * BIT_CYCLES;
        target = fall_count + 1;
        while (fall_count < target && limit > 0) begin
            next_cycle();
            limit--;
        end
        if (fall_count < target) begin
            error_count++;
            $display("vsync_out did not fall after a frame of %0d bytes", bytes);
        end
        if (expect_q.size() != 0) begin
            error_count++;
            $display("%0d bytes of the frame never appeared on the line", expect_q.size());
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // line decoder and compare

    // three samples per bit: just after its start, mid-bit, just before its end
    initial begin : line_decoder
        logic [9:0] bits;
        logic       early;
        logic       late;
        wait (reset == 1'b0);
        forever begin
            @(negedge uart_tx);
            for (int k = 0; k < uart_pkg::BITS_PER_FRAME; k++) begin
                @(negedge clock);
                early = uart_tx;
                repeat (BIT_CYCLES / 2) @(negedge clock);
                bits[k] = uart_tx;
                repeat (BIT_CYCLES - 1 - BIT_CYCLES / 2) @(negedge clock);
                late = uart_tx;
                check_value("uart_tx bit start", early, bits[k]);
                check_value("uart_tx bit end", late, bits[k]);
            end
            line_idle_cycle = cycles;
            check_value("uart_tx start bit", bits[0], 1'b0);
            check_value("uart_tx stop bit", bits[9], 1'b1);
            rx_q.push_back(bits[8:1]);              // LSB first
            -> byte_decoded;
        end
    end

    initial begin : compare_bytes
        frame_pkg::byte_t got;
        forever begin
            @(byte_decoded);
            while (rx_q.size() != 0) begin
                got = rx_q.pop_front();
                rx_count++;
                if (expect_q.size() == 0) begin
                    error_count++;
                    $display("byte %h appeared on the line with no frame pending", got);
                end else begin
                    check_value("uart_tx byte", got, expect_q.pop_front());
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // vsync_out holdoff

    always @(posedge vsync_out) begin
        rise_cycle = cycles;
    end

    always @(negedge vsync_out) begin : fall_timing
        int idle_ref;
        if (!reset) begin
            idle_ref = (line_idle_cycle > rise_cycle) ? line_idle_cycle : rise_cycle;
            fall_count++;
            if ((cycles - idle_ref) < HOLDOFF_CYCLES - BIT_CYCLES ||
                (cycles - idle_ref) > HOLDOFF_CYCLES + BIT_CYCLES) begin
                error_count++;
                $display("vsync_out fell %0d cycles after the line went idle, expected about %0d",
                         cycles - idle_ref, HOLDOFF_CYCLES);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    initial begin : stimulus
        int checker_errors;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        repeat (40) begin                           // quiet until the first edge
            next_cycle();
            check_value("uart_tx", uart_tx, 1'b1);
            check_value("vsync_out", vsync_out, 1'b0);
        end
        pulse_vsync();                              // empty first frame
        wait_frame_done(0);

        write_frame(LEN_A);
        repeat (20) begin                           // not sent before its edge
            next_cycle();
            check_value("uart_tx", uart_tx, 1'b1);
        end
        pulse_vsync();
        write_frame(LEN_B);                         // fills the other bank meanwhile
        wait_frame_done(LEN_A);
        pulse_vsync();
        wait_frame_done(LEN_B);

        write_frame(LEN_LONG);
        pulse_vsync();
        wait_frame_done(BANK_DEPTH);
        repeat (20) next_cycle();
        check_value("bytes received", rx_count, LINE_BYTES);

        checker_errors = dut.serializer.line_checker.fail_count;
        $display("errors: %0d compare, %0d assertion, %0d bytes received",
                 error_count, checker_errors, rx_count);
        if (error_count == 0 && checker_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with the test still running", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/frame_config.svh ====
/*
 * build-time sizing for the frame transmitter
 *   - bank address width (bytes per bank)
 *   - line bit period in clocks
 *   - vsync_out holdoff in byte times
 *   - serializer credit count
 */

`ifndef FRAME_CONFIG_SVH
`define FRAME_CONFIG_SVH

// 2**10 = 1024 bytes per bank
`define FB_ADDR_WIDTH 10

// 13 clocks per bit, roughly 921600 baud from 12 MHz
`define UART_CLOCKS_PER_BIT 13

// idle byte times after the last stop bit before vsync_out drops
`define HOLDOFF_BYTES 8

// holding register plus shift register
`define UART_CREDITS 2

`endif

// ==== verilog/frame_pkg.sv ====
/*
 * buffer-side types
 *   byte_t   data byte
 *   addr_t   bank address
 *   count_t  frame length, one bit wider than addr_t
 *   bank_t   bank select
 */

`default_nettype none

`include "frame_config.svh"

package frame_pkg;

    // bytes per bank
    localparam int BANK_DEPTH = 1 << `FB_ADDR_WIDTH;

    typedef logic [7:0] byte_t;

    typedef logic [`FB_ADDR_WIDTH-1:0] addr_t;

    // a full bank needs the extra bit
    typedef logic [`FB_ADDR_WIDTH:0] count_t;

    typedef logic bank_t;

endpackage

`default_nettype wire

// ==== verilog/frame_reader.sv ====
/*
 * frame_reader
 *   read pointer over the closed frame, credit counter toward the
 *   serializer, RAM byte hand-off on tx_valid, vsync_out holdoff
 */

`default_nettype none

`include "frame_config.svh"

module frame_reader (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire logic            swap,
    input  frame_pkg::count_t    frame_bytes,
    output frame_pkg::addr_t     read_addr,
    input  frame_pkg::byte_t     read_data,
    input  wire logic            credit_return,
    output logic                 tx_valid,
    output frame_pkg::byte_t     tx_data,
    input  wire logic            uart_tx_idle,
    output logic                 vsync_out
);

    localparam int HOLDOFF_CYCLES =
        `HOLDOFF_BYTES * uart_pkg::BITS_PER_FRAME * `UART_CLOCKS_PER_BIT;
    localparam int HOLD_W = $clog2(HOLDOFF_CYCLES + 1);

    frame_pkg::count_t rd_ptr;
    logic              pending;         // RAM read in flight
    logic              issue;
    logic              drained;
    uart_pkg::credit_t credits;
    logic [HOLD_W-1:0] hold_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // read side

    assign read_addr = rd_ptr[`FB_ADDR_WIDTH-1:0];

    // one read at a time, never in the swap cycle
    assign issue = !swap && !pending && (rd_ptr < frame_bytes) && (credits != '0);

    assign tx_valid = pending & ~swap;  // a swap drops the byte in flight
    assign tx_data  = read_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_ptr  <= '0;
            pending <= 1'b0;
        end else begin
            pending <= issue;
            if (swap) begin
                rd_ptr <= '0;
            end else if (issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // credits

    always_ff @(posedge clock) begin
        if (reset) begin
            credits <= uart_pkg::credit_t'(`UART_CREDITS);
        end else begin
            case ({tx_valid, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;    // none, or one each way
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // vsync_out holdoff

    assign drained = (rd_ptr >= frame_bytes) && !pending && uart_tx_idle;

    always_ff @(posedge clock) begin
        if (reset) begin
            vsync_out <= 1'b0;
            hold_cnt  <= '0;
        end else if (swap) begin
            vsync_out <= 1'b1;
            hold_cnt  <= '0;
        end else if (vsync_out) begin
            if (!drained) begin
                hold_cnt <= '0;             // line busy again, start over
            end else if (hold_cnt == HOLD_W'(HOLDOFF_CYCLES - 1)) begin
                vsync_out <= 1'b0;
            end else begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/frame_uart_top.sv ====
/*
 * frame_uart_top
 *   double-buffered frame to UART transmitter: writer, ping-pong
 *   RAM banks, reader and 8N1 serializer
 */

`default_nettype none

module frame_uart_top (
    input  wire logic            clock,
    input  wire logic            reset,
    input  frame_pkg::byte_t     data_in,
    input  wire logic            data_in_valid,
    input  wire logic            vsync_in,
    output logic                 uart_tx,
    output logic                 vsync_out
);

    frame_pkg::bank_t  write_bank;
    logic              write_en;
    frame_pkg::addr_t  write_addr;
    frame_pkg::byte_t  write_data;
    logic              swap;
    frame_pkg::count_t frame_bytes;
    frame_pkg::addr_t  read_addr;
    frame_pkg::byte_t  read_data;
    logic              tx_valid;
    frame_pkg::byte_t  tx_data;
    logic              credit_return;
    logic              uart_tx_idle;

    frame_writer writer (
        .clock        (clock),
        .reset        (reset),
        .data_in      (data_in),
        .data_in_valid(data_in_valid),
        .vsync_in     (vsync_in),
        .write_bank   (write_bank),
        .write_en     (write_en),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .swap         (swap),
        .frame_bytes  (frame_bytes)
    );

    pingpong_store store (
        .clock     (clock),
        .write_bank(write_bank),
        .write_en  (write_en),
        .write_addr(write_addr),
        .write_data(write_data),
        .read_addr (read_addr),
        .read_data (read_data)
    );

    frame_reader reader (
        .clock        (clock),
        .reset        (reset),
        .swap         (swap),
        .frame_bytes  (frame_bytes),
        .read_addr    (read_addr),
        .read_data    (read_data),
        .credit_return(credit_return),
        .tx_valid     (tx_valid),
        .tx_data      (tx_data),
        .uart_tx_idle (uart_tx_idle),
        .vsync_out    (vsync_out)
    );

    uart_serializer serializer (
        .clock        (clock),
        .reset        (reset),
        .tx_valid     (tx_valid),
        .tx_data      (tx_data),
        .credit_return(credit_return),
        .uart_tx      (uart_tx),
        .uart_tx_idle (uart_tx_idle)
    );

endmodule

`default_nettype wire

// ==== verilog/frame_writer.sv ====
/*
 * frame_writer
 *   input registers, vsync rising edge detect, write pointer with
 *   saturation at bank depth, bank toggle and frame length latch
 */

`default_nettype none

`include "frame_config.svh"

module frame_writer (
    input  wire logic            clock,
    input  wire logic            reset,
    input  frame_pkg::byte_t     data_in,
    input  wire logic            data_in_valid,
    input  wire logic            vsync_in,
    output frame_pkg::bank_t     write_bank,
    output logic                 write_en,
    output frame_pkg::addr_t     write_addr,
    output frame_pkg::byte_t     write_data,
    output logic                 swap,
    output frame_pkg::count_t    frame_bytes
);

    frame_pkg::byte_t  data_q;
    logic              valid_q;
    logic              vsync_meta;      // first sample of vsync_in
    logic              vsync_prev;      // second sample, for the edge
    frame_pkg::count_t wr_ptr;
    logic              full;

    ////////////////////////////////////////////////////////////////////////////
    // input sampling

    always_ff @(posedge clock) begin
        data_q <= data_in;                  // payload only
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q    <= 1'b0;
            vsync_meta <= 1'b0;
            vsync_prev <= 1'b0;
            swap       <= 1'b0;
        end else begin
            valid_q    <= data_in_valid;
            vsync_meta <= vsync_in;
            vsync_prev <= vsync_meta;
            swap       <= vsync_meta & ~vsync_prev;   // one cycle per rising edge
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // write side

    assign full       = (wr_ptr == frame_pkg::count_t'(frame_pkg::BANK_DEPTH));
    assign write_en   = valid_q & ~full;    // bytes past the bank depth are lost
    assign write_addr = wr_ptr[`FB_ADDR_WIDTH-1:0];
    assign write_data = data_q;

    // a byte written in the swap cycle still lands in the old bank,
    // so it is counted into the frame being closed
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr      <= '0;
            write_bank  <= 1'b0;
            frame_bytes <= '0;
        end else if (swap) begin
            frame_bytes <= wr_ptr + frame_pkg::count_t'(write_en);
            wr_ptr      <= '0;
            write_bank  <= ~write_bank;
        end else if (write_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pingpong_store.sv ====
/*
 * pingpong_store
 *   two byte-wide RAM banks with registered read
 *   write port goes to write_bank, read port to the other bank
 */

`default_nettype none

module pingpong_store (
    input  wire logic            clock,
    input  frame_pkg::bank_t     write_bank,
    input  wire logic            write_en,
    input  frame_pkg::addr_t     write_addr,
    input  frame_pkg::byte_t     write_data,
    input  frame_pkg::addr_t     read_addr,
    output frame_pkg::byte_t     read_data
);

    frame_pkg::byte_t bank_q [2];       // registered read of each bank
    frame_pkg::bank_t read_bank_q;      // bank that bank_q was read for

    ////////////////////////////////////////////////////////////////////////////
    // banks

    for (genvar b = 0; b < 2; b++) begin : g_bank
        frame_pkg::byte_t mem [frame_pkg::BANK_DEPTH];
        logic             bank_we;

        assign bank_we = write_en && (write_bank == frame_pkg::bank_t'(b));

        always_ff @(posedge clock) begin
            if (bank_we) begin
                mem[write_addr] <= write_data;
            end
            bank_q[b] <= mem[read_addr];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read mux

    // the select is captured with the read itself, so a swap between
    // address and data does not flip the mux under a byte in flight
    always_ff @(posedge clock) begin
        read_bank_q <= ~write_bank;
    end

    assign read_data = bank_q[read_bank_q];

endmodule

`default_nettype wire

// ==== verilog/uart_pkg.sv ====
/*
 * line-side types and constants
 *   tx_state_t      serializer state
 *   BITS_PER_FRAME  line bits per 8N1 byte
 *   credit_t        reader credit counter
 */

`default_nettype none

package uart_pkg;

    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_t;

    // start + 8 data + stop
    localparam int BITS_PER_FRAME = 10;

    typedef logic [1:0] credit_t;

endpackage

`default_nettype wire

// ==== verilog/uart_serializer.sv ====
/*
 * uart_serializer
 *   8N1 transmitter, LSB first, with one holding register ahead of
 *   the shift register; returns one credit per finished byte
 */

`default_nettype none

`include "frame_config.svh"

module uart_serializer (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire logic            tx_valid,
    input  frame_pkg::byte_t     tx_data,
    output logic                 credit_return,
    output logic                 uart_tx,
    output logic                 uart_tx_idle
);

    localparam int CNT_W = $clog2(`UART_CLOCKS_PER_BIT);

    uart_pkg::tx_state_t state;
    logic [CNT_W-1:0]    clk_cnt;       // clocks into the current bit
    logic [2:0]          bit_idx;
    frame_pkg::byte_t    shift;
    frame_pkg::byte_t    hold_data;
    logic                hold_full;
    logic                bit_done;
    logic                stop_done;
    logic                load;
    frame_pkg::byte_t    load_byte;

    assign bit_done  = (clk_cnt == CNT_W'(`UART_CLOCKS_PER_BIT - 1));
    assign stop_done = (state == uart_pkg::TX_STOP) && bit_done;

    // shifter takes the held byte, or the incoming one directly when empty
    assign load      = (state == uart_pkg::TX_IDLE || stop_done) && (hold_full || tx_valid);
    assign load_byte = hold_full ? hold_data : tx_data;

    assign uart_tx_idle = (state == uart_pkg::TX_IDLE) && !hold_full;

    ////////////////////////////////////////////////////////////////////////////
    // holding register

    always_ff @(posedge clock) begin
        if (reset) begin
            hold_full <= 1'b0;
        end else if (load && hold_full) begin
            hold_full <= tx_valid;          // refill behind the byte just taken
        end else if (!load && tx_valid) begin
            hold_full <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (tx_valid) begin
            hold_data <= tx_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // shifter

    always_ff @(posedge clock) begin
        if (reset) begin
            state         <= uart_pkg::TX_IDLE;
            clk_cnt       <= '0;
            bit_idx       <= '0;
            uart_tx       <= 1'b1;
            credit_return <= 1'b0;
        end else begin
            // a slot frees at the end of every stop bit; with the holding
            // register full this is the cycle its byte moves into the shifter
            credit_return <= stop_done;
            clk_cnt       <= (bit_done || state == uart_pkg::TX_IDLE) ? '0 : clk_cnt + 1'b1;

            if (load) begin
                state   <= uart_pkg::TX_START;
                shift   <= load_byte;
                clk_cnt <= '0;
                uart_tx <= 1'b0;            // start bit
            end else if (bit_done) begin
                case (state)
                    uart_pkg::TX_START: begin
                        state   <= uart_pkg::TX_DATA;
                        bit_idx <= '0;
                        uart_tx <= shift[0];
                        shift   <= shift >> 1;
                    end
                    uart_pkg::TX_DATA: begin
                        if (bit_idx == 3'd7) begin
                            state   <= uart_pkg::TX_STOP;
                            uart_tx <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            uart_tx <= shift[0];
                            shift   <= shift >> 1;
                        end
                    end
                    default: begin
                        state   <= uart_pkg::TX_IDLE;   // stop bit over, nothing queued
                        uart_tx <= 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire
